/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

  parameter int DEFAULT_XLEN = 64;
  parameter logic [63:0] DEFAULT_RESET_PC = 64'h0;

  // Instruction word and field widths
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B // LUI
  } alu_op_e;

  // Operand source seen by execute
  typedef enum logic {
    FWD_REG,
    FWD_EX
  } fwd_sel_e;

endpackage

/* rtl/decode_exec_if.sv */
`timescale 1ns/100ps

interface decode_exec_if #(
  parameter int XLEN = rv_core_pkg::DEFAULT_XLEN
);

  import rv_core_pkg::*;

  logic            valid;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  alu_op_e         alu_op;
  reg_idx_t        rd;
  logic            write_rd;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  logic            is_final;

  modport source (
    output valid, op_a, op_b, alu_op, rd, write_rd, fwd_a, fwd_b, is_final
  );

  modport sink (
    input valid, op_a, op_b, alu_op, rd, write_rd, fwd_a, fwd_b, is_final
  );

endinterface

/* rtl/reg_read_if.sv */
`timescale 1ns/100ps

interface reg_read_if #(
  parameter int XLEN = rv_core_pkg::DEFAULT_XLEN
);

  import rv_core_pkg::*;

  reg_idx_t        raddr_a;
  reg_idx_t        raddr_b;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;

  modport reader (output raddr_a, raddr_b, input rdata_a, rdata_b);
  modport file (input raddr_a, raddr_b, output rdata_a, rdata_b);

endinterface

/* rtl/register_file.sv */
`timescale 1ns/100ps

module register_file #(
  parameter int XLEN = rv_core_pkg::DEFAULT_XLEN
) (
  input  logic                  clk,
  input  logic                  rst_n,
  reg_read_if.file              rf,
  input  logic                  wr_en,
  input  rv_core_pkg::reg_idx_t wr_idx,
  input  logic [XLEN-1:0]       wr_value
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [1:31];

  // x0 reads zero, a write in flight wins over the stored value
  function automatic logic [XLEN-1:0] read_port(reg_idx_t idx);
    logic [XLEN-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (wr_en && wr_idx == idx) begin
      value = wr_value;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    rf.rdata_a = read_port(rf.raddr_a);
    rf.rdata_b = read_port(rf.raddr_b);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_value;
    end
  end

endmodule

/* rtl/instruction_fetch.sv */
`timescale 1ns/100ps

module instruction_fetch #(
  parameter int              XLEN     = rv_core_pkg::DEFAULT_XLEN,
  parameter logic [XLEN-1:0] RESET_PC = XLEN'(rv_core_pkg::DEFAULT_RESET_PC)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                halt,
  output logic                imem_req,
  output logic [XLEN-1:0]     imem_addr,
  input  logic                imem_ack,
  input  rv_core_pkg::instr_t imem_data,
  output logic                instr_valid,
  output rv_core_pkg::instr_t instr,
  output logic [XLEN-1:0]     instr_pc
);

  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_RELEASE
  } fetch_state_e;

  fetch_state_e    state;
  logic [XLEN-1:0] pc;
  logic            capture;
  instr_t          instr_q;
  logic [XLEN-1:0] instr_pc_q;
  logic            instr_valid_q;

  assign capture   = (state == WAIT_ACK) && imem_ack;
  assign imem_req  = (state == WAIT_ACK);
  assign imem_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IDLE;
      pc            <= RESET_PC;
      instr_valid_q <= 1'b0;
    end else begin
      instr_valid_q <= capture;
      case (state)
        IDLE: begin
          if (!halt && !imem_ack) begin
            state <= WAIT_ACK;
          end
        end
        WAIT_ACK: begin
          if (imem_ack) begin
            state <= WAIT_RELEASE;
            pc    <= pc + XLEN'(4);
          end
        end
        WAIT_RELEASE: begin
          // Next request only once the responder let go of ack
          if (!imem_ack) begin
            state <= halt ? IDLE : WAIT_ACK;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // One-entry buffer, valid for a single cycle
  always_ff @(posedge clk) begin
    if (capture) begin
      instr_q    <= imem_data;
      instr_pc_q <= pc;
    end
  end

  assign instr_valid = instr_valid_q;
  assign instr       = instr_q;
  assign instr_pc    = instr_pc_q;

endmodule

/* rtl/instruction_decode.sv */
`timescale 1ns/100ps

module instruction_decode #(
  parameter int XLEN = rv_core_pkg::DEFAULT_XLEN
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  rv_core_pkg::instr_t instr,
  input  logic [XLEN-1:0]     instr_pc,
  reg_read_if.reader          rf,
  decode_exec_if.source       dx
);

  import rv_core_pkg::*;

  opcode_t         opcode;
  funct3_t         funct3;
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  reg_idx_t        rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic            known;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            writes;
  logic            is_ecall;
  alu_op_e         funct_op;
  alu_op_e         alu_op_d;
  logic [XLEN-1:0] op_a_d;
  logic [XLEN-1:0] op_b_d;
  logic            ex_writes;
  fwd_sel_e        fwd_a_d;
  fwd_sel_e        fwd_b_d;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign imm_i  = XLEN'($signed(instr[31:20]));
  assign imm_u  = XLEN'($signed({instr[31:12], 12'b0}));

  assign rf.raddr_a = rs1;
  assign rf.raddr_b = rs2;

  // Shared funct3 map of OP and OP-IMM, SUB only exists in OP
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      3'b111:  funct_op = ALU_AND;
      default: funct_op = ALU_ADD;
    endcase
  end

  always_comb begin
    known    = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    writes   = 1'b0;
    is_ecall = 1'b0;
    alu_op_d = ALU_ADD;
    op_a_d   = '0;
    op_b_d   = '0;
    case (opcode)
      OPC_OP_IMM: begin
        known    = (funct3 != 3'b011);
        uses_rs1 = 1'b1;
        writes   = 1'b1;
        alu_op_d = funct_op;
        op_a_d   = rf.rdata_a;
        op_b_d   = imm_i;
      end
      OPC_OP: begin
        known    = (funct3 != 3'b011);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        writes   = 1'b1;
        alu_op_d = funct_op;
        op_a_d   = rf.rdata_a;
        op_b_d   = rf.rdata_b;
      end
      OPC_LUI: begin
        known    = 1'b1;
        writes   = 1'b1;
        alu_op_d = ALU_PASS_B;
        op_b_d   = imm_u;
      end
      OPC_AUIPC: begin
        known  = 1'b1;
        writes = 1'b1;
        op_a_d = instr_pc;
        op_b_d = imm_u;
      end
      OPC_SYSTEM: begin
        known    = (instr[31:7] == '0);
        is_ecall = known;
      end
      default: ;
    endcase
  end

  // Instruction now entering execute's result register
  assign ex_writes = dx.valid && dx.write_rd;
  assign fwd_a_d   = (uses_rs1 && ex_writes && dx.rd == rs1) ? FWD_EX : FWD_REG;
  assign fwd_b_d   = (uses_rs2 && ex_writes && dx.rd == rs2) ? FWD_EX : FWD_REG;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dx.valid    <= 1'b0;
      dx.write_rd <= 1'b0;
      dx.is_final <= 1'b0;
    end else begin
      dx.valid    <= instr_valid && known;
      dx.write_rd <= writes && (rd != '0);
      dx.is_final <= is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    dx.op_a   <= op_a_d;
    dx.op_b   <= op_b_d;
    dx.alu_op <= alu_op_d;
    dx.rd     <= rd;
    dx.fwd_a  <= fwd_a_d;
    dx.fwd_b  <= fwd_b_d;
  end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage #(
  parameter int XLEN = rv_core_pkg::DEFAULT_XLEN
) (
  input  logic                  clk,
  input  logic                  rst_n,
  decode_exec_if.sink           dx,
  output logic                  wr_en,
  output rv_core_pkg::reg_idx_t wr_idx,
  output logic [XLEN-1:0]       wr_value,
  output logic                  retire_valid,
  output rv_core_pkg::reg_idx_t retire_rd,
  output logic [XLEN-1:0]       retire_value,
  output logic                  done
);

  import rv_core_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] result_q;
  reg_idx_t        rd_q;
  logic            retire_q;
  logic            done_q;

  // Forward from our own result register
  assign op_a  = (dx.fwd_a == FWD_EX) ? result_q : dx.op_a;
  assign op_b  = (dx.fwd_b == FWD_EX) ? result_q : dx.op_b;
  assign shamt = op_b[SHW-1:0];

  always_comb begin
    case (dx.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLT:    alu_out = XLEN'($signed(op_a) < $signed(op_b));
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_SLL:    alu_out = op_a << shamt;
      ALU_SRL:    alu_out = op_a >> shamt;
      ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      retire_q <= dx.valid && dx.write_rd && !done_q;
      // Sticky once ECALL has reached this stage
      if (dx.valid && dx.is_final) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dx.valid) begin
      result_q <= alu_out;
      rd_q     <= dx.rd;
    end
  end

  assign wr_en        = retire_q;
  assign wr_idx       = rd_q;
  assign wr_value     = result_q;
  assign retire_valid = retire_q;
  assign retire_rd    = rd_q;
  assign retire_value = result_q;
  assign done         = done_q;

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top #(
  parameter int              XLEN     = rv_core_pkg::DEFAULT_XLEN,
  parameter logic [XLEN-1:0] RESET_PC = XLEN'(rv_core_pkg::DEFAULT_RESET_PC)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  imem_req,
  output logic [XLEN-1:0]       imem_addr,
  input  logic                  imem_ack,
  input  rv_core_pkg::instr_t   imem_data,
  output logic                  retire_valid,
  output rv_core_pkg::reg_idx_t retire_rd,
  output logic [XLEN-1:0]       retire_value,
  output logic                  done
);

  import rv_core_pkg::*;

  logic            instr_valid;
  instr_t          instr;
  logic [XLEN-1:0] instr_pc;
  logic            wr_en;
  reg_idx_t        wr_idx;
  logic [XLEN-1:0] wr_value;

  reg_read_if #(.XLEN(XLEN)) rf_bus ();
  decode_exec_if #(.XLEN(XLEN)) dx_bus ();

  instruction_fetch #(
    .XLEN    (XLEN),
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk,
    .rst_n,
    .halt       (done),
    .imem_req,
    .imem_addr,
    .imem_ack,
    .imem_data,
    .instr_valid,
    .instr,
    .instr_pc
  );

  instruction_decode #(.XLEN(XLEN)) u_decode (
    .clk,
    .rst_n,
    .instr_valid,
    .instr,
    .instr_pc,
    .rf         (rf_bus.reader),
    .dx         (dx_bus.source)
  );

  execute_stage #(.XLEN(XLEN)) u_execute (
    .clk,
    .rst_n,
    .dx          (dx_bus.sink),
    .wr_en,
    .wr_idx,
    .wr_value,
    .retire_valid,
    .retire_rd,
    .retire_value,
    .done
  );

  register_file #(.XLEN(XLEN)) u_regfile (
    .clk,
    .rst_n,
    .rf      (rf_bus.file),
    .wr_en,
    .wr_idx,
    .wr_value
  );

endmodule

/* testbench/rv_core_props.sv */
`timescale 1ns/100ps

module rv_core_props #(
  parameter int              XLEN     = rv_core_pkg::DEFAULT_XLEN,
  parameter logic [XLEN-1:0] RESET_PC = XLEN'(rv_core_pkg::DEFAULT_RESET_PC)
) (
  input logic            clk,
  input logic            rst_n,
  input logic            imem_req,
  input logic [XLEN-1:0] imem_addr,
  input logic            imem_ack,
  input logic            retire_valid,
  input logic            done
);

  int              violations = 0;
  logic [XLEN-1:0] next_addr;

  // Address the next request has to carry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr <= RESET_PC;
    end else if (imem_req && imem_ack) begin
      next_addr <= next_addr + XLEN'(4);
    end
  end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req && !imem_ack |=> imem_req)
    else begin
      violations++;
      $error("imem_req dropped before imem_ack was seen");
    end

  req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(imem_req) |-> !imem_ack)
    else begin
      violations++;
      $error("imem_req rose while imem_ack was still high");
    end

  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req && $past(imem_req) |-> $stable(imem_addr))
    else begin
      violations++;
      $error("imem_addr changed during a request");
    end

  addr_sequence: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req |-> imem_addr == next_addr)
    else begin
      violations++;
      $error("imem_addr out of sequence");
    end

  done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> done)
    else begin
      violations++;
      $error("done fell after rising");
    end

  no_retire_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !retire_valid)
    else begin
      violations++;
      $error("retire_valid high after done");
    end

  no_req_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !$rose(imem_req))
    else begin
      violations++;
      $error("new instruction request after done");
    end

endmodule

bind rv_core_top rv_core_props #(
  .XLEN    (XLEN),
  .RESET_PC(RESET_PC)
) u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .imem_req    (imem_req),
  .imem_addr   (imem_addr),
  .imem_ack    (imem_ack),
  .retire_valid(retire_valid),
  .done        (done)
);

/* testbench/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

  import rv_core_pkg::*;

  localparam int XLEN           = 64;
  localparam int PROG_LEN       = 48;
  localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 50;

  logic            clk = 1'b0;
  logic            rst_n = 1'b0;
  logic            imem_req;
  logic [XLEN-1:0] imem_addr;
  logic            imem_ack = 1'b0;
  instr_t          imem_data = '0;
  logic            retire_valid;
  reg_idx_t        retire_rd;
  logic [XLEN-1:0] retire_value;
  logic            done;

  integer          seed;
  instr_t          prog [0:PROG_LEN];
  logic [63:0]     model_regs [0:31];
  reg_idx_t        exp_rd [$];
  logic [63:0]     exp_value [$];
  reg_idx_t        want_rd;
  logic [63:0]     want_value;
  int              expected_total = 0;
  int              retired = 0;
  int              value_errors = 0;
  int              other_errors = 0;
  int              cycles = 0;
  int              ack_wait = 0;
  int              rel_wait = 0;

  rv_core_top #(
    .XLEN    (XLEN),
    .RESET_PC(64'h0)
  ) u_rv_core_top (
    .clk,
    .rst_n,
    .imem_req,
    .imem_addr,
    .imem_ack,
    .imem_data,
    .retire_valid,
    .retire_rd,
    .retire_value,
    .done
  );

  always #50 clk = ~clk;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic build_program();
    int          kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [5:0]  sh;
    for (int i = 0; i < PROG_LEN; i++) begin
      kind  = rand_below(19);
      // Only x0..x7, so dependencies sit close together
      rd    = reg_idx_t'(rand_below(8));
      rs1   = reg_idx_t'(rand_below(8));
      rs2   = reg_idx_t'(rand_below(8));
      imm   = 12'($random(seed));
      upper = 20'($random(seed));
      sh    = 6'(rand_below(64));
      case (kind)
        0:  prog[i] = {imm, rs1, 3'b000, rd, OPC_OP_IMM};
        1:  prog[i] = {imm, rs1, 3'b010, rd, OPC_OP_IMM};
        2:  prog[i] = {imm, rs1, 3'b100, rd, OPC_OP_IMM};
        3:  prog[i] = {imm, rs1, 3'b110, rd, OPC_OP_IMM};
        4:  prog[i] = {imm, rs1, 3'b111, rd, OPC_OP_IMM};
        5:  prog[i] = {6'b000000, sh, rs1, 3'b001, rd, OPC_OP_IMM};
        6:  prog[i] = {6'b000000, sh, rs1, 3'b101, rd, OPC_OP_IMM};
        7:  prog[i] = {6'b010000, sh, rs1, 3'b101, rd, OPC_OP_IMM};
        8:  prog[i] = {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
        9:  prog[i] = {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};
        10: prog[i] = {7'h00, rs2, rs1, 3'b001, rd, OPC_OP};
        11: prog[i] = {7'h00, rs2, rs1, 3'b010, rd, OPC_OP};
        12: prog[i] = {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
        13: prog[i] = {7'h00, rs2, rs1, 3'b101, rd, OPC_OP};
        14: prog[i] = {7'h20, rs2, rs1, 3'b101, rd, OPC_OP};
        15: prog[i] = {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
        16: prog[i] = {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
        17: prog[i] = {upper, rd, OPC_LUI};
        default: prog[i] = {upper, rd, OPC_AUIPC};
      endcase
    end
    prog[PROG_LEN] = 32'h0000_0073;
  endtask

  // RV64 semantics of one instruction against the model registers
  function automatic logic [63:0] ref_result(instr_t w, logic [63:0] pc);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] upper;
    logic [5:0]  sh;
    logic [63:0] res;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm   = {{52{w[31]}}, w[31:20]};
    upper = {{32{w[31]}}, w[31:12], 12'b0};
    res   = '0;
    if (w[6:0] == OPC_OP_IMM) begin
      b  = imm;
      sh = w[25:20];
    end else begin
      sh = b[5:0];
    end
    case (w[6:0])
      OPC_OP_IMM, OPC_OP: begin
        case (w[14:12])
          3'b000: res = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
          3'b001: res = a << sh;
          3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'b100: res = a ^ b;
          3'b101: begin
            if (w[30]) begin
              res = $signed(a) >>> sh;
            end else begin
              res = a >> sh;
            end
          end
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      OPC_LUI:   res = upper;
      OPC_AUIPC: res = pc + upper;
      default:   res = '0;
    endcase
    return res;
  endfunction

  task automatic run_model();
    logic [63:0] value;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      value = ref_result(prog[i], 64'(i) * 64'd4);
      if (prog[i][11:7] != 5'd0) begin
        model_regs[prog[i][11:7]] = value;
        exp_rd.push_back(prog[i][11:7]);
        exp_value.push_back(value);
      end
    end
    expected_total = exp_rd.size();
  endtask

  function automatic instr_t fetch_word(logic [XLEN-1:0] addr);
    instr_t word;
    // Words past the ECALL write x1 and must never retire
    word = {12'(addr % 64'd4093), 5'd0, 3'b000, 5'd1, OPC_OP_IMM};
    if (addr[63:2] < 62'(PROG_LEN + 1)) begin
      word = prog[addr[7:2]];
    end
    return word;
  endfunction

  // Four-phase instruction responder
  always @(posedge clk) begin
    if (!rst_n) begin
      imem_ack <= 1'b0;
      ack_wait <= rand_below(4);
    end else if (!imem_ack) begin
      if (imem_req) begin
        if (ack_wait == 0) begin
          imem_ack  <= 1'b1;
          imem_data <= fetch_word(imem_addr);
          rel_wait  <= rand_below(3);
        end else begin
          ack_wait <= ack_wait - 1;
        end
      end
    end else if (!imem_req) begin
      if (rel_wait == 0) begin
        imem_ack <= 1'b0;
        ack_wait <= rand_below(4);
      end else begin
        rel_wait <= rel_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && retire_valid) begin
      retired++;
      if (exp_rd.size() == 0) begin
        other_errors++;
        $display("Retirement of x%0d after the last expected one", retire_rd);
      end else begin
        want_rd    = exp_rd.pop_front();
        want_value = exp_value.pop_front();
        rd_check: assert (retire_rd == want_rd) else begin
          value_errors++;
          $display("** Error: retire_rd = %h, expected %h", retire_rd, want_rd);
        end
        value_check: assert (retire_value == want_value) else begin
          value_errors++;
          $display("** Error: retire_value = %h, expected %h", retire_value, want_value);
        end
      end
    end
  end

  task automatic finish_run(bit timed_out);
    int props_failed;
    int total;
    props_failed = u_rv_core_top.u_props.violations;
    total        = value_errors + other_errors + props_failed + int'(timed_out);
    $display("Error counts: value %0d, other %0d, property %0d, timeout %0d",
             value_errors, other_errors, props_failed, int'(timed_out));
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    seed = 32'hda2e_85d7;
    build_program();
    run_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    while (!done) begin
      @(posedge clk);
    end
    // Open fetch and anything behind ECALL must stay silent
    repeat (20) @(posedge clk);
    count_check: assert (retired == expected_total) else begin
      other_errors++;
      $display("Retired %0d instructions while the program has %0d", retired, expected_total);
    end
    finish_run(1'b0);
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: done did not rise within %0d cycles", cycles);
    finish_run(1'b1);
  end

endmodule

/* list.f */
rtl/rv_core_pkg.sv
rtl/decode_exec_if.sv
rtl/reg_read_if.sv
rtl/register_file.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execute_stage.sv
rtl/rv_core_top.sv
testbench/rv_core_props.sv
testbench/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core +verilator+error+limit+10000 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without reported failures"
